//--- build.f
+incdir+include
design/cpu_pkg.sv
design/control_unit.sv
design/execute_unit.sv
design/register_bank.sv
design/data_memory.sv
design/cpu_top.sv
test/cpu_tb.sv

//--- design/control_unit.sv
module control_unit (
    input  logic              instr_valid,
    input  cpu_pkg::opcode_e  opcode,
    output logic              load_a,
    output logic              load_b,
    output logic              mem_write,
    output logic              load_flags,
    output cpu_pkg::src_a_e   src_a,
    output cpu_pkg::src_b_e   src_b,
    output cpu_pkg::alu_op_e  alu_op
);
    import cpu_pkg::*;

    logic    known;       // Opcode is in the table
    logic    active;
    logic    dst_a;
    logic    dst_b;
    logic    dst_mem;
    src_a_e  sel_a;
    src_b_e  sel_b;
    alu_op_e op;

    always_comb begin
        known   = 1'b1;
        op      = ALU_ADD;
        sel_a   = SRC_A_REG_A;
        sel_b   = SRC_B_REG_B;  // Also the don't-care for unary ops

        // ALU operation per family
        case (opcode)
            OP_MOV_A_B, OP_MOV_B_A, OP_MOV_A_LIT, OP_MOV_B_LIT,
            OP_ADD_A_B, OP_ADD_B_A, OP_ADD_A_LIT, OP_ADD_B_LIT, OP_ADD_A_DIR,
            OP_INC_B, OP_INC_DIR, OP_RST_DIR:                          op = ALU_ADD;
            OP_SUB_A_B, OP_SUB_B_A, OP_SUB_A_LIT, OP_SUB_B_LIT, OP_SUB_A_DIR: op = ALU_SUB;
            OP_AND_A_B, OP_AND_B_A, OP_AND_A_LIT, OP_AND_B_LIT, OP_AND_A_DIR: op = ALU_AND;
            OP_OR_A_B, OP_OR_B_A, OP_OR_A_LIT, OP_OR_B_LIT, OP_OR_A_DIR:      op = ALU_OR;
            OP_XOR_A_B, OP_XOR_B_A, OP_XOR_A_LIT, OP_XOR_B_LIT, OP_XOR_A_DIR: op = ALU_XOR;
            OP_NOT_A_A, OP_NOT_A_B, OP_NOT_B_A, OP_NOT_B_B, OP_NOT_DIR_A:     op = ALU_NOT;
            OP_SHL_A_A, OP_SHL_A_B, OP_SHL_B_A, OP_SHL_B_B, OP_SHL_DIR_A:     op = ALU_SHL;
            OP_SHR_A_A, OP_SHR_A_B, OP_SHR_B_A, OP_SHR_B_B:                   op = ALU_SHR;
            default:                                                   known = 1'b0;
        endcase

        // Destination, one opcode list per target
        dst_a   = opcode inside {OP_MOV_A_B, OP_MOV_A_LIT, OP_ADD_A_B, OP_ADD_A_LIT,
                                 OP_SUB_A_B, OP_SUB_A_LIT, OP_AND_A_B, OP_AND_A_LIT,
                                 OP_OR_A_B, OP_OR_A_LIT, OP_XOR_A_B, OP_XOR_A_LIT,
                                 OP_NOT_A_A, OP_NOT_A_B, OP_SHL_A_A, OP_SHL_A_B,
                                 OP_SHR_A_A, OP_SHR_A_B, OP_ADD_A_DIR, OP_SUB_A_DIR,
                                 OP_AND_A_DIR, OP_OR_A_DIR, OP_XOR_A_DIR};
        dst_b   = opcode inside {OP_MOV_B_A, OP_MOV_B_LIT, OP_ADD_B_A, OP_ADD_B_LIT,
                                 OP_SUB_B_A, OP_SUB_B_LIT, OP_AND_B_A, OP_AND_B_LIT,
                                 OP_OR_B_A, OP_OR_B_LIT, OP_XOR_B_A, OP_XOR_B_LIT,
                                 OP_NOT_B_A, OP_NOT_B_B, OP_SHL_B_A, OP_SHL_B_B,
                                 OP_SHR_B_A, OP_SHR_B_B, OP_INC_B};
        dst_mem = opcode inside {OP_NOT_DIR_A, OP_SHL_DIR_A, OP_INC_DIR, OP_RST_DIR};

        // x operand, register A unless listed
        case (opcode)
            OP_ADD_B_LIT, OP_SUB_B_LIT, OP_AND_B_LIT, OP_OR_B_LIT, OP_XOR_B_LIT,
            OP_NOT_A_B, OP_NOT_B_B, OP_SHL_A_B, OP_SHL_B_B, OP_SHR_A_B, OP_SHR_B_B:
                sel_a = SRC_A_REG_B;
            OP_MOV_A_B, OP_MOV_A_LIT, OP_MOV_B_LIT, OP_RST_DIR:
                sel_a = SRC_A_ZERO;  // Moves are 0 + y
            OP_INC_B, OP_INC_DIR:
                sel_a = SRC_A_ONE;
            default: ;
        endcase

        // y operand, register B unless listed
        case (opcode)
            OP_MOV_A_LIT, OP_MOV_B_LIT, OP_ADD_A_LIT, OP_ADD_B_LIT, OP_SUB_A_LIT,
            OP_SUB_B_LIT, OP_AND_A_LIT, OP_AND_B_LIT, OP_OR_A_LIT, OP_OR_B_LIT,
            OP_XOR_A_LIT, OP_XOR_B_LIT:
                sel_b = SRC_B_LIT;
            OP_ADD_A_DIR, OP_SUB_A_DIR, OP_AND_A_DIR, OP_OR_A_DIR, OP_XOR_A_DIR,
            OP_INC_DIR:
                sel_b = SRC_B_MEM;
            OP_MOV_B_A, OP_RST_DIR:
                sel_b = SRC_B_ZERO;
            default: ;
        endcase
    end

    assign active     = instr_valid && known;  // Unknown opcode behaves as a bubble
    assign load_a     = active && dst_a;
    assign load_b     = active && dst_b;
    assign mem_write  = active && dst_mem;
    assign load_flags = active;
    assign src_a      = active ? sel_a : SRC_A_REG_A;
    assign src_b      = active ? sel_b : SRC_B_REG_B;
    assign alu_op     = active ? op : ALU_ADD;

    // One destination per instruction
    always_comb begin
        assert (!(mem_write && (load_a || load_b)) && !(load_a && load_b))
            else $error("control_unit: more than one destination enabled");
    end

endmodule

//--- design/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // Opcode table, one row per instruction family
    typedef enum logic [`OPCODE_W-1:0] {
        OP_MOV_A_B = 7'h00, OP_MOV_B_A = 7'h01, OP_MOV_A_LIT = 7'h02, OP_MOV_B_LIT = 7'h03,
        OP_ADD_A_B = 7'h04, OP_ADD_B_A = 7'h05, OP_ADD_A_LIT = 7'h06, OP_ADD_B_LIT = 7'h07,
        OP_SUB_A_B = 7'h08, OP_SUB_B_A = 7'h09, OP_SUB_A_LIT = 7'h0A, OP_SUB_B_LIT = 7'h0B,
        OP_AND_A_B = 7'h0C, OP_AND_B_A = 7'h0D, OP_AND_A_LIT = 7'h0E, OP_AND_B_LIT = 7'h0F,
        OP_OR_A_B  = 7'h10, OP_OR_B_A  = 7'h11, OP_OR_A_LIT  = 7'h12, OP_OR_B_LIT  = 7'h13,
        OP_NOT_A_A = 7'h14, OP_NOT_A_B = 7'h15, OP_NOT_B_A   = 7'h16, OP_NOT_B_B   = 7'h17,
        OP_XOR_A_B = 7'h18, OP_XOR_B_A = 7'h19, OP_XOR_A_LIT = 7'h1A, OP_XOR_B_LIT = 7'h1B,
        OP_SHL_A_A = 7'h1C, OP_SHL_A_B = 7'h1D, OP_SHL_B_A   = 7'h1E, OP_SHL_B_B   = 7'h1F,
        OP_SHR_A_A = 7'h20, OP_SHR_A_B = 7'h21, OP_SHR_B_A   = 7'h22, OP_SHR_B_B   = 7'h23,
        OP_INC_B   = 7'h24,
        OP_ADD_A_DIR = 7'h2C, OP_SUB_A_DIR = 7'h30, OP_AND_A_DIR = 7'h34,  // Mem[Lit] operand
        OP_OR_A_DIR  = 7'h38, OP_XOR_A_DIR = 7'h3F,
        OP_NOT_DIR_A = 7'h3C, OP_SHL_DIR_A = 7'h43,                        // Mem[Lit] destination
        OP_INC_DIR   = 7'h49, OP_RST_DIR   = 7'h4B
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOT = 4'd5,   // Inverts x only
        ALU_SHL = 4'd6,
        ALU_SHR = 4'd7    // Zero fill from the top
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_REG_A = 2'b00,
        SRC_A_REG_B = 2'b01,
        SRC_A_ZERO  = 2'b10,
        SRC_A_ONE   = 2'b11   // Used by the increments
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_REG_B = 2'b00,
        SRC_B_MEM   = 2'b01,  // Word at Mem[Lit]
        SRC_B_LIT   = 2'b10,
        SRC_B_ZERO  = 2'b11
    } src_b_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } status_t;

endpackage

//--- design/cpu_top.sv
`include "cpu_defines.svh"

module cpu_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  cpu_pkg::opcode_e    opcode,
    input  logic [`DATA_W-1:0]  literal,
    output logic [`DATA_W-1:0]  reg_a,
    output logic [`DATA_W-1:0]  reg_b,
    output cpu_pkg::status_t    flags
);
    import cpu_pkg::*;

    logic               load_a;
    logic               load_b;
    logic               mem_write;
    logic               load_flags;
    src_a_e             src_a;
    src_b_e             src_b;
    alu_op_e            alu_op;
    logic [`DATA_W-1:0] result;
    logic [`DATA_W-1:0] mem_rdata;
    status_t            next_flags;

    control_unit u_control (
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .load_a      (load_a),
        .load_b      (load_b),
        .mem_write   (mem_write),
        .load_flags  (load_flags),
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_op      (alu_op)
    );

    execute_unit u_execute (
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_op      (alu_op),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .literal     (literal),
        .mem_rdata   (mem_rdata),
        .result      (result),
        .next_flags  (next_flags)
    );

    register_bank u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_a      (load_a),
        .load_b      (load_b),
        .load_flags  (load_flags),
        .result      (result),
        .next_flags  (next_flags),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .flags       (flags)
    );

    // Literal doubles as the direct address
    data_memory u_dmem (
        .clk         (clk),
        .mem_write   (mem_write),
        .addr        (literal),
        .wdata       (result),
        .rdata       (mem_rdata)
    );

endmodule

//--- design/data_memory.sv
`include "cpu_defines.svh"

module data_memory (
    input  logic                clk,
    input  logic                mem_write,
    input  logic [`DATA_W-1:0]  addr,
    input  logic [`DATA_W-1:0]  wdata,
    output logic [`DATA_W-1:0]  rdata
);

    logic [`DATA_W-1:0] mem [`MEM_DEPTH];

    assign rdata = mem[addr];  // Same-cycle read for the Dir operand

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[addr] <= wdata;
        end
    end

    // A write to an unknown address would corrupt an unknown word
    ap_addr_known: assert property (
        @(posedge clk) mem_write |-> !$isunknown(addr)
    ) else $error("data_memory: write with unknown address");

endmodule

//--- design/execute_unit.sv
`include "cpu_defines.svh"

module execute_unit (
    input  cpu_pkg::src_a_e         src_a,
    input  cpu_pkg::src_b_e         src_b,
    input  cpu_pkg::alu_op_e        alu_op,
    input  logic [`DATA_W-1:0]      reg_a,
    input  logic [`DATA_W-1:0]      reg_b,
    input  logic [`DATA_W-1:0]      literal,
    input  logic [`DATA_W-1:0]      mem_rdata,
    output logic [`DATA_W-1:0]      result,
    output cpu_pkg::status_t        next_flags
);
    import cpu_pkg::*;

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0] op_x;
    logic [`DATA_W-1:0] op_y;
    logic [`DATA_W:0]   wide;    // Extra bit holds carry or borrow
    logic               carry;
    logic               ovf;

    // Operand selection
    always_comb begin
        case (src_a)
            SRC_A_REG_A: op_x = reg_a;
            SRC_A_REG_B: op_x = reg_b;
            SRC_A_ZERO:  op_x = '0;
            default:     op_x = {{MSB{1'b0}}, 1'b1};
        endcase
        case (src_b)
            SRC_B_REG_B: op_y = reg_b;
            SRC_B_MEM:   op_y = mem_rdata;
            SRC_B_LIT:   op_y = literal;
            default:     op_y = '0;
        endcase
    end

    always_comb begin
        wide   = '0;
        result = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                wide   = {1'b0, op_x} + {1'b0, op_y};
                result = wide[MSB:0];
                carry  = wide[`DATA_W];
                ovf    = (op_x[MSB] == op_y[MSB]) && (result[MSB] != op_x[MSB]);
            end
            ALU_SUB: begin
                wide   = {1'b0, op_x} - {1'b0, op_y};
                result = wide[MSB:0];
                carry  = wide[`DATA_W];  // Set when x < y unsigned
                ovf    = (op_x[MSB] != op_y[MSB]) && (result[MSB] != op_x[MSB]);
            end
            ALU_AND: result = op_x & op_y;
            ALU_OR:  result = op_x | op_y;
            ALU_XOR: result = op_x ^ op_y;
            ALU_NOT: result = ~op_x;
            ALU_SHL: begin
                result = {op_x[MSB-1:0], 1'b0};
                carry  = op_x[MSB];
            end
            ALU_SHR: begin
                result = {1'b0, op_x[MSB:1]};
                carry  = op_x[0];
            end
            default: ;
        endcase
    end

    assign next_flags = '{z: (result == '0), n: result[MSB], c: carry, v: ovf};

    always_comb begin
        assert (alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                               ALU_XOR, ALU_NOT, ALU_SHL, ALU_SHR})
            else $error("execute_unit: undefined ALU operation %h", alu_op);
    end

endmodule

//--- design/register_bank.sv
`include "cpu_defines.svh"

module register_bank (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                load_a,
    input  logic                load_b,
    input  logic                load_flags,
    input  logic [`DATA_W-1:0]  result,
    input  cpu_pkg::status_t    next_flags,
    output logic [`DATA_W-1:0]  reg_a,
    output logic [`DATA_W-1:0]  reg_b,
    output cpu_pkg::status_t    flags
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_a <= '0;
        end else if (load_a) begin
            reg_a <= result;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_b <= '0;
        end else if (load_b) begin
            reg_b <= result;
        end
    end

    // Status updates on every decoded instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (load_flags) begin
            flags <= next_flags;
        end
    end

    ap_enables_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown({load_a, load_b, load_flags})
    ) else $error("register_bank: load enable is unknown");

endmodule

//--- include/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Registers, literal, memory words and ALU all share this width
`define DATA_W 8

`define OPCODE_W 7  // Opcode field of an instruction

// Whole literal is the data address
`define MEM_DEPTH 256

`endif

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f build.f -o cpu_sim
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0

//--- test/cpu_tb.sv
`include "cpu_defines.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int MAX_TESTS = 128;
    localparam int FIELDS    = 5;  // Opcode, literal, A, B, flags

    logic               clk;
    logic               arst_n;
    logic               instr_valid;
    opcode_e            opcode;
    logic [`DATA_W-1:0] literal;
    logic [`DATA_W-1:0] reg_a;
    logic [`DATA_W-1:0] reg_b;
    status_t            flags;

    logic [15:0] vectors [MAX_TESTS*FIELDS];  // Unused words keep 16'hFFFF
    int          num_tests;
    int          cycle_limit;
    int          cycles;
    int          checks;
    int          errors;
    int          line_idx;

    cpu_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .literal     (literal),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog on the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: got %h expected %h (test line %0d)",
                     name, actual, expected, line_idx);
        end
    endtask

    task automatic drive_line(input int idx);
        logic [15:0] op_word;
        op_word     = vectors[idx*FIELDS];
        instr_valid = !op_word[7];  // Bit 7 marks a cycle with no strobe
        opcode      = opcode_e'(op_word[6:0]);
        literal     = vectors[idx*FIELDS+1][7:0];
    endtask

    task automatic check_line(input int idx);
        line_idx = idx;
        check_value("reg_a", reg_a, vectors[idx*FIELDS+2][7:0]);
        check_value("reg_b", reg_b, vectors[idx*FIELDS+3][7:0]);
        check_value("flags", {4'h0, flags}, vectors[idx*FIELDS+4][7:0]);
    endtask

    initial begin
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        opcode      = OP_MOV_A_B;
        literal     = '0;
        cycles      = 0;
        cycle_limit = 0;
        checks      = 0;
        errors      = 0;
        line_idx    = -1;

        for (int i = 0; i < MAX_TESTS*FIELDS; i++) begin
            vectors[i] = 16'hFFFF;
        end
        $readmemh("test/cpu_tests.txt", vectors);
        num_tests = 0;
        while (num_tests < MAX_TESTS && vectors[num_tests*FIELDS] != 16'hFFFF) begin
            num_tests++;
        end
        cycle_limit = num_tests * 2 + 50;
        if (num_tests == 0) begin
            $display("No test lines could be read from test/cpu_tests.txt");
            errors++;
        end

        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        check_value("reg_a", reg_a, 8'h00);  // Cleared by reset
        check_value("reg_b", reg_b, 8'h00);
        check_value("flags", {4'h0, flags}, 8'h00);

        // Back to back, one line per cycle
        for (int i = 0; i < num_tests; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_line(i - 1);
            end
            drive_line(i);
        end
        @(negedge clk);
        if (num_tests > 0) begin
            check_line(num_tests - 1);
        end
        instr_valid = 1'b0;

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- test/cpu_tests.txt
// opcode literal exp_a exp_b exp_flags, hex, flags packed as {z,n,c,v}
// Opcode with bit 7 set keeps instr_valid low for that cycle
02 3C 3C 00 0
03 A5 3C A5 4
04 00 E1 A5 4
00 00 A5 A5 4
06 5B 00 A5 A
01 00 00 00 8
02 7F 7F 00 0
07 01 7F 01 0
04 00 80 01 5
05 00 80 81 4
06 81 01 81 3
08 00 80 81 7
0A 01 7F 81 1
09 00 7F FE 7
0B FE 7F 00 8
03 F0 7F F0 4
0C 00 70 F0 0
0D 00 70 70 0
0E 0F 00 70 8
0F C0 00 40 0
10 00 40 40 0
13 81 40 C1 4
12 0A 4A C1 0
11 00 4A CB 4
18 00 81 CB 4
1A 81 00 CB 8
19 00 00 CB 4
1B 0F 00 C4 4
15 00 3B C4 0
20 00 1D C4 2
22 00 1D 0E 2
21 00 07 0E 0
23 00 07 07 0
1C 00 0E 07 0
17 00 0E F8 4
1F 00 0E F0 6
1D 00 E0 F0 6
1E 00 E0 C0 6
14 00 1F C0 0
16 00 1F E0 4
03 FF 1F FF 4
24 00 1F 00 A
4B 20 1F 00 8
49 20 1F 00 0
3C 21 1F 00 4
43 22 1F 00 0
02 00 00 00 8
2C 20 01 00 0
02 00 00 00 8
2C 21 E0 00 4
02 00 00 00 8
2C 22 3E 00 0
34 21 20 00 0
38 20 21 00 0
30 22 E3 00 6
3F 22 DD 00 4
82 55 DD 00 4
7E 55 DD 00 4
06 23 00 00 A
